/* hw/nocPkg.sv */
`default_nettype none

package nocPkg;

  // five links per router: local plus four mesh neighbours
  localparam int numPorts = 5;

  typedef logic [2:0] flitIdT;

  typedef logic [31:0] payloadT;

  // number of flits a port may forward in one grant
  typedef logic [11:0] holdLenT;

  // source port index, local 0 up to south 4
  typedef logic [2:0] portIdxT;

  // values of the flit type field
  typedef enum flitIdT {
    flitIdle = 3'd0,
    flitHead = 3'd1,
    flitBody = 3'd2,
    flitTail = 3'd3
  } flitKindE;

  // hold limit in force until a port forwards its first head flit
  localparam holdLenT defaultHold = 12'd4;

  // grantX numbering follows the port index plus one
  typedef enum logic [2:0] {
    idle   = 3'd0,
    grantL = 3'd1,
    grantN = 3'd2,
    grantE = 3'd3,
    grantW = 3'd4,
    grantS = 3'd5
  } arbStateE;

endpackage

`default_nettype wire

/* hw/inputBuffer.sv */
`default_nettype none

module inputBuffer #(
  parameter int fifoDepth = 4
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            inValid,
  input  nocPkg::flitIdT  inFlitId,
  input  nocPkg::payloadT inPayload,
  output logic            inReady,
  output logic            req,
  output nocPkg::flitIdT  headFlitId,
  output nocPkg::payloadT headPayload,
  input  logic            granted,
  input  logic            pop,
  output logic            timesUp
);

  localparam int ptrW = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
  localparam int cntW = $clog2(fifoDepth + 1);

  nocPkg::flitIdT  flitMem [fifoDepth];
  nocPkg::payloadT payloadMem [fifoDepth];

  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] fillCnt;
  logic            push;
  logic            popHead;

  nocPkg::holdLenT holdCnt;
  nocPkg::holdLenT holdLimit;

  // pointers wrap at the last entry, so the depth need not be a power of two
  function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
    if (ptr == ptrW'(fifoDepth - 1))
    begin
      return '0;
    end
    return ptr + ptrW'(1);
  endfunction

  assign inReady = (fillCnt != cntW'(fifoDepth));
  assign req = (fillCnt != '0);
  assign push = inValid && inReady;

  assign headFlitId = flitMem[rdPtr];
  assign headPayload = payloadMem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      flitMem[wrPtr] <= inFlitId;
      payloadMem[wrPtr] <= inPayload;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      fillCnt <= '0;
    end
    else
    begin
      if (push)
      begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop)
      begin
        rdPtr <= nextPtr(rdPtr);
      end
      // simultaneous push and pop leaves the count unchanged
      if (push && !pop)
      begin
        fillCnt <= fillCnt + cntW'(1);
      end
      else if (pop && !push)
      begin
        fillCnt <= fillCnt - cntW'(1);
      end
    end
  end

  // hold timer counts flits sent under the current grant
  assign popHead = pop && (headFlitId == nocPkg::flitHead);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      holdCnt <= '0;
      holdLimit <= nocPkg::defaultHold;
    end
    else
    begin
      if (!granted)
      begin
        holdCnt <= '0;
      end
      else if (pop)
      begin
        holdCnt <= holdCnt + 12'd1;
      end
      if (popHead)
      begin
        holdLimit <= headPayload[$bits(nocPkg::holdLenT)-1:0];
      end
    end
  end

  // a head popped mid-grant may lower the limit below the count
  assign timesUp = (holdCnt != '0) && (holdCnt >= holdLimit);

endmodule

`default_nettype wire

/* hw/switchArbiter.sv */
`default_nettype none

module switchArbiter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [nocPkg::numPorts-1:0] req,
  input  logic [nocPkg::numPorts-1:0] timesUp,
  input  nocPkg::flitIdT              headFlitId [nocPkg::numPorts],
  input  nocPkg::payloadT             headPayload [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0] granted,
  output logic [nocPkg::numPorts-1:0] pop,
  output logic                        outValid,
  output nocPkg::flitIdT              outFlitId,
  output nocPkg::payloadT             outPayload,
  output nocPkg::portIdxT             outPort,
  input  logic                        outReady
);

  nocPkg::arbStateE state;
  nocPkg::arbStateE nextState;
  nocPkg::portIdxT  grantIdx;
  logic             grantValid;
  logic             keepGrant;
  logic             outFree;
  logic             popAny;

  // first requesting port among span ports, scanning up from first with wrap
  function automatic nocPkg::arbStateE pickNext(
    input logic [nocPkg::numPorts-1:0] r,
    input int first,
    input int span
  );
    int idx;
    nocPkg::arbStateE pick;
    pick = nocPkg::idle;
    // scan downwards so the lowest offset wins
    for (int i = nocPkg::numPorts - 1; i >= 0; i--)
    begin
      idx = first + i;
      if (idx >= nocPkg::numPorts)
      begin
        idx = idx - nocPkg::numPorts;
      end
      if ((i < span) && r[idx])
      begin
        pick = nocPkg::arbStateE'(idx + 1);
      end
    end
    return pick;
  endfunction

  // port owned by the current state
  always_comb
  begin
    grantValid = 1'b1;
    case (state)
      nocPkg::grantL:
      begin
        grantIdx = 3'd0;
      end
      nocPkg::grantN:
      begin
        grantIdx = 3'd1;
      end
      nocPkg::grantE:
      begin
        grantIdx = 3'd2;
      end
      nocPkg::grantW:
      begin
        grantIdx = 3'd3;
      end
      nocPkg::grantS:
      begin
        grantIdx = 3'd4;
      end
      default:
      begin
        grantIdx = 3'd0;
        grantValid = 1'b0;
      end
    endcase
  end

  assign keepGrant = grantValid && req[grantIdx] && !timesUp[grantIdx];

  always_comb
  begin
    if (!grantValid)
    begin
      // fixed priority L, N, E, W, S out of idle
      nextState = pickNext(req, 0, nocPkg::numPorts);
    end
    else if (keepGrant)
    begin
      nextState = state;
    end
    else
    begin
      // the other four ports in rotated order; none left means idle
      nextState = pickNext(req, int'(grantIdx) + 1, nocPkg::numPorts - 1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= nocPkg::idle;
    end
    else
    begin
      state <= nextState;
    end
  end

  // output register is free when empty or its flit leaves this edge
  assign outFree = !outValid || outReady;

  always_comb
  begin
    granted = '0;
    pop = '0;
    if (grantValid)
    begin
      granted[grantIdx] = 1'b1;
      pop[grantIdx] = keepGrant && outFree;
    end
  end

  assign popAny = |pop;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else if (popAny)
    begin
      outValid <= 1'b1;
    end
    else if (outReady)
    begin
      outValid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (popAny)
    begin
      outFlitId <= headFlitId[grantIdx];
      outPayload <= headPayload[grantIdx];
      outPort <= grantIdx;
    end
  end

endmodule

`default_nettype wire

/* hw/routerOutputPort.sv */
`default_nettype none

module routerOutputPort #(
  parameter int fifoDepth = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [nocPkg::numPorts-1:0] inValid,
  input  nocPkg::flitIdT              inFlitId [nocPkg::numPorts],
  input  nocPkg::payloadT             inPayload [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0] inReady,
  output logic                        outValid,
  output nocPkg::flitIdT              outFlitId,
  output nocPkg::payloadT             outPayload,
  output nocPkg::portIdxT             outPort,
  input  logic                        outReady
);

  logic [nocPkg::numPorts-1:0] req;
  logic [nocPkg::numPorts-1:0] timesUp;
  logic [nocPkg::numPorts-1:0] granted;
  logic [nocPkg::numPorts-1:0] pop;

  // front entry of every buffer, seen by the arbiter mux
  nocPkg::flitIdT  headFlitId [nocPkg::numPorts];
  nocPkg::payloadT headPayload [nocPkg::numPorts];

  // one buffer per link, index order L, N, E, W, S
  for (genvar p = 0; p < nocPkg::numPorts; p++)
  begin : genBuffer
    inputBuffer #(
      .fifoDepth(fifoDepth)
    ) i_inputBuffer (
      .clk        (clk),
      .rst        (rst),
      .inValid    (inValid[p]),
      .inFlitId   (inFlitId[p]),
      .inPayload  (inPayload[p]),
      .inReady    (inReady[p]),
      .req        (req[p]),
      .headFlitId (headFlitId[p]),
      .headPayload(headPayload[p]),
      .granted    (granted[p]),
      .pop        (pop[p]),
      .timesUp    (timesUp[p])
    );
  end

  switchArbiter i_switchArbiter (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .timesUp    (timesUp),
    .headFlitId (headFlitId),
    .headPayload(headPayload),
    .granted    (granted),
    .pop        (pop),
    .outValid   (outValid),
    .outFlitId  (outFlitId),
    .outPayload (outPayload),
    .outPort    (outPort),
    .outReady   (outReady)
  );

endmodule

`default_nettype wire

/* include/flitModel.svh */
`ifndef FLIT_MODEL_SVH
`define FLIT_MODEL_SVH

// expected flits per source port as {flit id, payload}
logic [34:0]     expQ [nocPkg::numPorts][$];
nocPkg::holdLenT modelLimit [nocPkg::numPorts];
int              lastPort;
int              runLen;
int              inCount;
int              outCount;

task automatic clearModel();
  for (int p = 0; p < nocPkg::numPorts; p++)
  begin
    expQ[p].delete();
    modelLimit[p] = nocPkg::defaultHold;
  end
  lastPort = -1;
  runLen = 0;
  inCount = 0;
  outCount = 0;
endtask

task automatic pushExpected(input int p, input logic [34:0] flit);
  expQ[p].push_back(flit);
  inCount++;
endtask

task automatic takeExpected(input int p, output logic found, output logic [34:0] flit);
  found = (expQ[p].size() != 0);
  flit = '0;
  if (found)
  begin
    flit = expQ[p].pop_front();
  end
endtask

// extend or restart the run of consecutive flits from one port
// limit returned is the one in force before this flit
task automatic noteOutput(input int p, input logic [34:0] flit, output int prev,
                          output int len, output int limit);
  prev = lastPort;
  runLen = (p == lastPort) ? runLen + 1 : 1;
  len = runLen;
  limit = int'(modelLimit[p]);
  if (flit[34:32] == nocPkg::flitHead)
  begin
    modelLimit[p] = flit[11:0];
  end
  lastPort = p;
  outCount++;
endtask

`endif

/* tb/routerOutputPortTb.sv */
`default_nettype none

module routerOutputPortTb;

  localparam int numPorts = nocPkg::numPorts;
  localparam int satPackets = 6;
  localparam int rndPackets = 8;
  // longest packet is a head, six bodies and a tail
  localparam int maxFlits = numPorts * (satPackets + rndPackets) * 8;
  localparam int cycleLimit = maxFlits * 20 + 200;

  logic                clk;
  logic                rst;
  logic [numPorts-1:0] inValid;
  nocPkg::flitIdT      inFlitId [numPorts];
  nocPkg::payloadT     inPayload [numPorts];
  logic [numPorts-1:0] inReady;
  logic                outValid;
  nocPkg::flitIdT      outFlitId;
  nocPkg::payloadT     outPayload;
  nocPkg::portIdxT     outPort;
  logic                outReady;

  logic [31:0] rngState;
  int          pktLeft [numPorts];
  int          pktLen [numPorts];
  int          flitsLeft [numPorts];
  int          seq [numPorts];
  logic        saturated;
  logic        stallSeen;
  logic [37:0] stallFields;
  string       curTest;
  int          errors;
  int          testErrStart;
  int          testsRun;
  int          testsFailed;
  int          cycles = 0;

  `include "flitModel.svh"

  routerOutputPort #(
    .fifoDepth(4)
  ) i_dut (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .inFlitId  (inFlitId),
    .inPayload (inPayload),
    .inReady   (inReady),
    .outValid  (outValid),
    .outFlitId (outFlitId),
    .outPayload(outPayload),
    .outPort   (outPort),
    .outReady  (outReady)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic drawRandom(output logic [31:0] r);
    rngState = xorshift(rngState);
    r = rngState;
  endtask

  // advance every link by one cycle; bursty traffic leaves gaps between packets
  task automatic stepLinks(input logic bursty);
    logic [31:0] r;
    logic        busy;
    busy = 1'b1;
    for (int p = 0; p < numPorts; p++)
    begin
      if (!inValid[p] || inReady[p])
      begin
        if (inValid[p])
        begin
          flitsLeft[p]--;
        end
        drawRandom(r);
        if ((flitsLeft[p] == 0) && (pktLeft[p] != 0) && (!bursty || (r[1:0] == 2'd0)))
        begin
          pktLen[p] = 3 + int'(r[10:8] % 3'd6);
          flitsLeft[p] = pktLen[p];
          pktLeft[p]--;
        end
        if (flitsLeft[p] == 0)
        begin
          inValid[p] <= 1'b0;
        end
        else
        begin
          inValid[p] <= 1'b1;
          if (flitsLeft[p] == pktLen[p])
          begin
            // hold length 1 to 8 in the low bits
            inFlitId[p] <= nocPkg::flitHead;
            inPayload[p] <= {3'(p), 13'(seq[p]), 16'(r[4:2]) + 16'd1};
          end
          else
          begin
            inFlitId[p] <= (flitsLeft[p] == 1) ? nocPkg::flitTail : nocPkg::flitBody;
            inPayload[p] <= {3'(p), 13'(seq[p]), r[31:16]};
          end
          seq[p]++;
        end
      end
      busy = busy && (flitsLeft[p] != 0);
    end
    saturated <= !bursty && busy;
    drawRandom(r);
    outReady <= bursty ? r[7] : 1'b1;
  endtask

  function automatic logic trafficDone();
    logic done;
    done = (inCount == outCount);
    for (int p = 0; p < numPorts; p++)
    begin
      done = done && (flitsLeft[p] == 0) && (pktLeft[p] == 0);
    end
    return done;
  endfunction

  task automatic runTraffic(input logic bursty, input int packets);
    logic done;
    for (int p = 0; p < numPorts; p++)
    begin
      pktLeft[p] = packets;
    end
    done = 1'b0;
    while (!done)
    begin
      @(posedge clk);
      stepLinks(bursty);
      @(negedge clk);
      done = trafficDone();
    end
  endtask

  task automatic startTest(input string name);
    curTest = name;
    testErrStart = errors;
  endtask

  task automatic finishTest();
    testsRun++;
    if (errors != testErrStart)
    begin
      testsFailed++;
      $display("test %s FAIL with %0d errors", curTest, errors - testErrStart);
    end
    else
    begin
      $display("test %s ok", curTest);
    end
  endtask

  // model update and output checks
  always @(posedge clk)
  begin
    logic [34:0] expFlit;
    logic        found;
    int          prev;
    int          len;
    int          limit;
    if (!rst)
    begin
      for (int p = 0; p < numPorts; p++)
      begin
        if (inValid[p] && inReady[p])
        begin
          pushExpected(p, {inFlitId[p], inPayload[p]});
        end
      end
      if (stallSeen)
      begin
        assert ({outValid, outFlitId, outPayload, outPort} == {1'b1, stallFields})
        else
        begin
          $display("ERR %s stalled output expected %h actual %h", curTest,
                   {1'b1, stallFields}, {outValid, outFlitId, outPayload, outPort});
          errors++;
        end
      end
      stallSeen = outValid && !outReady;
      stallFields = {outFlitId, outPayload, outPort};
      if (outValid && outReady)
      begin
        takeExpected(int'(outPort), found, expFlit);
        assert (found)
        else
        begin
          $display("%s: flit from port %0d arrived while none was expected", curTest, outPort);
          errors++;
        end
        if (found)
        begin
          assert (expFlit == {outFlitId, outPayload})
          else
          begin
            $display("ERR %s flit from port %0d expected %h actual %h", curTest, outPort,
                     expFlit, {outFlitId, outPayload});
            errors++;
          end
        end
        noteOutput(int'(outPort), {outFlitId, outPayload}, prev, len, limit);
        if (saturated)
        begin
          assert (len <= limit)
          else
          begin
            $display("ERR %s run length of port %0d expected at most %0d actual %0d",
                     curTest, outPort, limit, len);
            errors++;
          end
          if ((prev >= 0) && (prev != int'(outPort)))
          begin
            assert (int'(outPort) == (prev + 1) % numPorts)
            else
            begin
              $display("ERR %s next port expected %0d actual %0d", curTest,
                       (prev + 1) % numPorts, outPort);
              errors++;
            end
          end
        end
      end
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit)
    begin
      $display("timeout, traffic did not drain within %0d cycles", cycleLimit);
      $display("Testbench failed");
      $finish;
    end
  end

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    inValid = '0;
    outReady = 1'b0;
    for (int p = 0; p < numPorts; p++)
    begin
      inFlitId[p] = '0;
      inPayload[p] = '0;
      flitsLeft[p] = 0;
      pktLeft[p] = 0;
      pktLen[p] = 0;
      seq[p] = 0;
    end
    rngState = 32'hcbe43789;
    saturated = 1'b0;
    stallSeen = 1'b0;
    stallFields = '0;
    errors = 0;
    testsRun = 0;
    testsFailed = 0;
    clearModel();

    startTest("reset");
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (!outValid)
    else
    begin
      $display("ERR %s outValid expected %h actual %h", curTest, 1'b0, outValid);
      errors++;
    end
    assert (inReady == '1)
    else
    begin
      $display("ERR %s inReady expected %h actual %h", curTest, 5'h1f, inReady);
      errors++;
    end
    finishTest();

    // all links busy, output always ready
    startTest("saturated");
    runTraffic(1'b0, satPackets);
    finishTest();

    startTest("backPressure");
    runTraffic(1'b1, rndPackets);
    finishTest();

    startTest("noLoss");
    for (int p = 0; p < numPorts; p++)
    begin
      assert (expQ[p].size() == 0)
      else
      begin
        $display("ERR %s port %0d queue size expected %0d actual %0d", curTest, p, 0,
                 expQ[p].size());
        errors++;
      end
    end
    finishTest();

    $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
    if (errors == 0)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
hw/nocPkg.sv
hw/inputBuffer.sv
hw/switchArbiter.sv
hw/routerOutputPort.sv
tb/routerOutputPortTb.sv

/* run.sh */
#!/bin/sh
# build and run the router output port testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module routerOutputPortTb -o simv \
  && ./obj_dir/simv | tee sim.log
grep -qx "Testbench passed" sim.log 2>/dev/null && echo "simulation PASS" \
  || { echo "simulation FAIL"; exit 1; }
